// File: bench/memory_hierarchy_tb.sv
`timescale 1ns/100ps

module memory_hierarchy_tb;

	localparam int INDEX_W     = 6;
	localparam int MEM_WORDS   = 1024;
	localparam int MEM_LATENCY = 4;
	localparam int MAX_ENTRIES = 32;

	// A/B and E/F pairs share a cache index with different tags
	localparam logic [mem_pkg::ADDR_W-1:0] A_ADDR = 32'h005;
	localparam logic [mem_pkg::ADDR_W-1:0] B_ADDR = 32'h045;
	localparam logic [mem_pkg::ADDR_W-1:0] C_ADDR = 32'h010;
	localparam logic [mem_pkg::ADDR_W-1:0] D_ADDR = 32'h020;
	localparam logic [mem_pkg::ADDR_W-1:0] E_ADDR = 32'h007;
	localparam logic [mem_pkg::ADDR_W-1:0] F_ADDR = 32'h047;

	logic                       clk;
	logic                       reset;
	logic                       ie, de, drw;
	logic [mem_pkg::ADDR_W-1:0] iaddr, daddr;
	logic [mem_pkg::WORD_W-1:0] din;
	logic [mem_pkg::WORD_W-1:0] iout, dout;
	logic                       cpu_stall;

	// Stimulus table with one row per processor access
	logic                       t_ie    [MAX_ENTRIES];
	logic                       t_de    [MAX_ENTRIES];
	logic                       t_drw   [MAX_ENTRIES];
	logic [mem_pkg::ADDR_W-1:0] t_iaddr [MAX_ENTRIES];
	logic [mem_pkg::ADDR_W-1:0] t_daddr [MAX_ENTRIES];
	logic [mem_pkg::WORD_W-1:0] t_din   [MAX_ENTRIES];
	logic                       t_chk_i [MAX_ENTRIES];  // Compare iout
	logic [mem_pkg::WORD_W-1:0] t_iexp  [MAX_ENTRIES];
	logic                       t_chk_d [MAX_ENTRIES];  // Compare dout
	logic [mem_pkg::WORD_W-1:0] t_dexp  [MAX_ENTRIES];
	logic                       t_hit   [MAX_ENTRIES];  // Must finish without a stall

	logic [mem_pkg::WORD_W-1:0] ref_mem [MEM_WORDS];    // Expected memory contents
	integer                     seed;
	int                         n_entries;
	int                         pass_cnt, fail_cnt;
	int                         cycles;
	int                         cycle_limit;

	memory_hierarchy #(
		.INDEX_W(INDEX_W),
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) memory_hierarchy_inst (
		.clk, .reset, .ie, .de, .drw, .iaddr, .daddr, .din,
		.iout, .dout, .cpu_stall
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;                               // 4 ns period

	// Run limit covers the flush and a worst case double operation per entry
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("timeout after %0d cycles, cpu_stall never released", cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	// Appends a row; expected words follow the write-through rule
	task automatic add_entry(input logic e_i, input logic e_d, input logic w,
			input logic [mem_pkg::ADDR_W-1:0] ia, input logic [mem_pkg::ADDR_W-1:0] da,
			input logic hit);
		int k;
		k = n_entries;
		t_ie[k]    = e_i;
		t_de[k]    = e_d;
		t_drw[k]   = w;
		t_iaddr[k] = ia;
		t_daddr[k] = da;
		t_din[k]   = w ? $random(seed) : '0;
		t_chk_i[k] = e_i;
		t_iexp[k]  = ref_mem[ia % MEM_WORDS];           // Fetch goes before a same-row write
		t_chk_d[k] = e_d && !w;
		t_dexp[k]  = ref_mem[da % MEM_WORDS];
		t_hit[k]   = hit;
		if (e_d && w)
			ref_mem[da % MEM_WORDS] = t_din[k];         // Memory always takes the write
		n_entries++;
	endtask

	task automatic build_table();
		add_entry(0, 1, 1, '0, A_ADDR, 0);               // First word
		add_entry(0, 1, 0, '0, A_ADDR, 1);               // Allocated on write so it hits
		add_entry(1, 0, 0, A_ADDR, '0, 0);               // Instruction side sees data write
		add_entry(0, 1, 1, '0, B_ADDR, 0);               // Evicts A from data cache
		add_entry(0, 1, 0, '0, A_ADDR, 0);               // Refill A from memory
		add_entry(0, 1, 0, '0, B_ADDR, 0);
		add_entry(1, 1, 0, B_ADDR, A_ADDR, 0);           // Both caches miss together
		add_entry(0, 1, 1, '0, C_ADDR, 0);
		add_entry(0, 1, 1, '0, D_ADDR, 0);
		add_entry(1, 1, 1, C_ADDR, D_ADDR, 0);           // Fetch miss with a write
		add_entry(1, 0, 0, D_ADDR, '0, 0);               // New D word
		add_entry(0, 1, 1, '0, E_ADDR, 0);
		add_entry(0, 1, 0, '0, E_ADDR, 1);
		add_entry(0, 1, 1, '0, E_ADDR, 0);               // Overwrite a cached word
		add_entry(0, 1, 0, '0, E_ADDR, 1);               // Cache holds the newer word
		add_entry(0, 1, 1, '0, F_ADDR, 0);               // Alias eviction
		add_entry(0, 1, 0, '0, E_ADDR, 0);
		add_entry(1, 0, 0, E_ADDR, '0, 0);
	endtask

	// Waits on falling edges until the stall drops and returns before the rising edge
	task automatic wait_ready(output int stalls);
		stalls = 0;
		#1;
		while (cpu_stall) begin
			stalls++;
			@(negedge clk);
			#1;
		end
	endtask

	task automatic run_entry(input int k);
		int  stalls;
		logic ok;
		ok = 1'b1;
		@(negedge clk);
		ie    <= 1'b0;                                  // Address settles for one cycle first
		de    <= 1'b0;
		drw   <= t_drw[k];
		iaddr <= t_iaddr[k];
		daddr <= t_daddr[k];
		din   <= t_din[k];
		@(negedge clk);
		ie <= t_ie[k];
		de <= t_de[k];
		wait_ready(stalls);
		if (t_chk_i[k])
			assert (iout === t_iexp[k]) else begin
				$display("Mismatch at %0t: entry %0d iout expected %h, got %h",
					$time, k, t_iexp[k], iout);
				ok = 1'b0;
			end
		if (t_chk_d[k])
			assert (dout === t_dexp[k]) else begin
				$display("Mismatch at %0t: entry %0d dout expected %h, got %h",
					$time, k, t_dexp[k], dout);
				ok = 1'b0;
			end
		if (t_hit[k])
			assert (stalls == 0) else begin
				$display("Entry %0d stalled %0d cycles on what should be a hit", k, stalls);
				ok = 1'b0;
			end
		@(posedge clk);                                 // Access completes here
		if (ok)
			pass_cnt++;
		else
			fail_cnt++;
		$display("entry %0d %s, %0d stall cycles", k, ok ? "ok" : "bad", stalls);
	endtask

	initial begin
		int flush_cycles;
		seed      = 32'hf9cd;
		reset     = 1'b1;
		ie        = 1'b0;
		de        = 1'b0;
		drw       = 1'b0;
		iaddr     = '0;
		daddr     = '0;
		din       = '0;
		cycles    = 0;
		pass_cnt  = 0;
		fail_cnt  = 0;
		n_entries = 0;
		build_table();
		cycle_limit = 64 + n_entries * (2 * MEM_LATENCY + 6);
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset <= 1'b0;
		@(negedge clk);
		wait_ready(flush_cycles);                       // Flush sweep holds the stall
		$display("flush released cpu_stall after %0d cycles", flush_cycles);
		for (int k = 0; k < n_entries; k++)
			run_entry(k);
		$display("%0d entries, %0d passed, %0d failed", n_entries, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: rtl/backing_memory.sv
`timescale 1ns/100ps

module backing_memory #(
	parameter int MEM_WORDS   = 1024,    // Depth in words
	parameter int MEM_LATENCY = 4        // Cycles from mem_req to mem_rdy
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       mem_req,
	input  logic                       mem_we,
	input  logic [mem_pkg::ADDR_W-1:0] mem_addr,
	input  logic [mem_pkg::WORD_W-1:0] mem_wdata,
	output logic                       mem_rdy,
	output logic [mem_pkg::WORD_W-1:0] mem_rdata
);

	localparam int MEM_AW = $clog2(MEM_WORDS);
	localparam int CNT_W  = $clog2(MEM_LATENCY + 1);
	localparam logic [mem_pkg::ADDR_W-1:0] WORDS_A = MEM_WORDS;

	logic [mem_pkg::WORD_W-1:0] ram [MEM_WORDS];   // Undefined until written

	logic                       busy;
	logic [CNT_W-1:0]           cnt;               // Cycles left until access
	logic                       done;
	logic                       req_we;            // Captured request
	logic [MEM_AW-1:0]          req_addr;
	logic [mem_pkg::WORD_W-1:0] req_wdata;

	assign done = busy && (cnt == CNT_W'(1));

	always_ff @(posedge clk) begin
		if (reset) begin
			busy    <= 1'b0;
			cnt     <= '0;
			mem_rdy <= 1'b0;
		end else begin
			mem_rdy <= done;                       // Pulse lands MEM_LATENCY after mem_req
			if (mem_req) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(MEM_LATENCY - 1);
			end else if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (mem_req) begin
			req_we    <= mem_we;
			req_addr  <= MEM_AW'(mem_addr % WORDS_A);  // Wrap to depth
			req_wdata <= mem_wdata;
		end
		if (done) begin
			if (req_we)
				ram[req_addr] <= req_wdata;
			mem_rdata <= ram[req_addr];            // Old word on a write
		end
	end

	initial
		assert (MEM_LATENCY >= 2) else $error("MEM_LATENCY below 2");

	// One request at a time
	assert property (@(posedge clk) disable iff (reset) mem_req |-> !busy);

	assert property (@(posedge clk) disable iff (reset)
		mem_req |-> ##MEM_LATENCY mem_rdy);

endmodule

// File: rtl/cache_array.sv
`timescale 1ns/100ps

module cache_array #(
	parameter int ADDR_BITS = 6,                 // Index width
	parameter int DATA_BITS = mem_pkg::WORD_W    // Entry width
) (
	input  logic                 clk,
	input  logic                 wea,            // Port a write strobe
	input  logic                 web,            // Port b write strobe
	input  logic [ADDR_BITS-1:0] addra,
	input  logic [ADDR_BITS-1:0] addrb,
	input  logic [DATA_BITS-1:0] dia,
	input  logic [DATA_BITS-1:0] dib,
	output logic [DATA_BITS-1:0] doa,            // Valid half a cycle after the rising edge
	output logic [DATA_BITS-1:0] dob
);

	localparam int DEPTH = 1 << ADDR_BITS;

	logic [DATA_BITS-1:0] ram [DEPTH];           // Inferred block RAM

	// Falling edge access, so a compare on doa settles before the next rising edge
	always_ff @(negedge clk) begin
		if (wea)
			ram[addra] <= dia;
		if (web)
			ram[addrb] <= dib;
		doa <= ram[addra];                       // Old contents on a same-edge write
		dob <= ram[addrb];
	end

endmodule

// File: rtl/cache_controller.sv
`timescale 1ns/100ps

module cache_controller #(
	parameter int INDEX_W = 6                                 // Cache index bits
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                ie,           // Instruction fetch level
	input  logic                                de,           // Data access level
	input  logic                                drw,          // Data write
	input  logic [mem_pkg::ADDR_W-1:0]          iaddr,
	input  logic [mem_pkg::ADDR_W-1:0]          daddr,
	input  logic [mem_pkg::WORD_W-1:0]          din,
	input  logic [mem_pkg::ADDR_W-INDEX_W:0]    inst_tag_q,   // Valid bit on top
	input  logic [mem_pkg::ADDR_W-INDEX_W:0]    data_tag_q,
	input  logic [mem_pkg::WORD_W-1:0]          inst_word_q,
	input  logic [mem_pkg::WORD_W-1:0]          data_word_q,
	output logic                                inst_wr,
	output logic                                data_wr,
	output logic [INDEX_W-1:0]                  inst_index,
	output logic [INDEX_W-1:0]                  data_index,
	output logic [mem_pkg::WORD_W-1:0]          inst_word_d,
	output logic [mem_pkg::WORD_W-1:0]          data_word_d,
	output logic [mem_pkg::ADDR_W-INDEX_W:0]    inst_tag_d,
	output logic [mem_pkg::ADDR_W-INDEX_W:0]    data_tag_d,
	output logic                                mem_req,      // One-cycle pulse
	output logic                                mem_we,
	output logic [mem_pkg::ADDR_W-1:0]          mem_addr,
	output logic [mem_pkg::WORD_W-1:0]          mem_wdata,
	input  logic                                mem_rdy,      // One-cycle pulse
	input  logic [mem_pkg::WORD_W-1:0]          mem_rdata,
	output logic [mem_pkg::WORD_W-1:0]          iout,
	output logic [mem_pkg::WORD_W-1:0]          dout,
	output logic                                cpu_stall
);

	localparam int TAG_W = mem_pkg::ADDR_W - INDEX_W;

	mem_pkg::cache_state_t state, next_state;
	logic [INDEX_W-1:0]    flush_cnt;      // Flush sweep index
	logic                  req_sent;       // Memory request of this phase is out
	logic                  wr_done;        // Write finished last cycle
	logic                  flushing;
	logic                  inst_phase;     // Memory busy for the instruction side
	logic                  data_phase;
	logic                  ihit, dhit;
	logic                  i_miss, d_miss, d_wr;

	assign ihit = inst_tag_q[TAG_W] &&
		(inst_tag_q[TAG_W-1:0] == iaddr[mem_pkg::ADDR_W-1:INDEX_W]);
	assign dhit = data_tag_q[TAG_W] &&
		(data_tag_q[TAG_W-1:0] == daddr[mem_pkg::ADDR_W-1:INDEX_W]);

	assign i_miss = ie && !ihit;
	assign d_miss = de && !drw && !dhit;   // Read miss only
	assign d_wr   = de && drw && !wr_done; // Every write goes through memory

	assign flushing   = state == mem_pkg::st_flush;
	assign inst_phase = state inside {mem_pkg::st_fill_inst, mem_pkg::st_fill_both,
		mem_pkg::st_write_inst};
	assign data_phase = state inside {mem_pkg::st_fill_data, mem_pkg::st_write};

	always_comb begin
		next_state = state;
		unique case (state)
			mem_pkg::st_flush:
				if (flush_cnt == '1)
					next_state = mem_pkg::st_idle;
			mem_pkg::st_idle:
				if (i_miss && d_wr)
					next_state = mem_pkg::st_write_inst;  // Fetch first, then write
				else if (i_miss && d_miss)
					next_state = mem_pkg::st_fill_both;
				else if (i_miss)
					next_state = mem_pkg::st_fill_inst;
				else if (d_wr)
					next_state = mem_pkg::st_write;
				else if (d_miss)
					next_state = mem_pkg::st_fill_data;
			mem_pkg::st_fill_both:
				if (mem_rdy)
					next_state = mem_pkg::st_fill_data;
			mem_pkg::st_write_inst:
				if (mem_rdy)
					next_state = mem_pkg::st_write;
			default:                                      // Last sequence of an operation
				if (mem_rdy)
					next_state = mem_pkg::st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= mem_pkg::st_flush;
			flush_cnt <= '0;
			req_sent  <= 1'b0;
			wr_done   <= 1'b0;
		end else begin
			state <= next_state;
			if (flushing)
				flush_cnt <= flush_cnt + 1'b1;
			if (mem_rdy)
				req_sent <= 1'b0;                         // Next phase issues afresh
			else if (mem_req)
				req_sent <= 1'b1;
			wr_done <= (state == mem_pkg::st_write) && mem_rdy;
		end
	end

	// Array side, flush writes invalid tags through both caches
	assign inst_wr     = flushing || (inst_phase && mem_rdy);
	assign data_wr     = flushing || (data_phase && mem_rdy);
	assign inst_index  = flushing ? flush_cnt : iaddr[INDEX_W-1:0];
	assign data_index  = flushing ? flush_cnt : daddr[INDEX_W-1:0];
	assign inst_word_d = mem_rdata;
	assign data_word_d = (state == mem_pkg::st_write) ? din : mem_rdata;  // Allocate on write
	assign inst_tag_d  = flushing ? '0 : {1'b1, iaddr[mem_pkg::ADDR_W-1:INDEX_W]};
	assign data_tag_d  = flushing ? '0 : {1'b1, daddr[mem_pkg::ADDR_W-1:INDEX_W]};

	// Memory side
	assign mem_req   = (inst_phase || data_phase) && !req_sent;
	assign mem_we    = state == mem_pkg::st_write;
	assign mem_addr  = data_phase ? daddr : iaddr;
	assign mem_wdata = din;

	assign iout      = inst_word_q;
	assign dout      = data_word_q;
	assign cpu_stall = (state != mem_pkg::st_idle) || i_miss || d_miss || d_wr;

	// A hit read touches no array and keeps the controller idle
	assert property (@(posedge clk) disable iff (reset)
		(state == mem_pkg::st_idle && (ie || de) && !drw && !cpu_stall)
			|-> (!inst_wr && !data_wr) ##1 (state == mem_pkg::st_idle));

	assert property (@(posedge clk) disable iff (reset)
		(state != mem_pkg::st_idle) |-> cpu_stall);

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

	localparam int WORD_W = 32;  // Data word width
	localparam int ADDR_W = 32;  // Word address width

	// Cache controller states, one stall sequence per non-idle state
	typedef enum logic [2:0] {
		st_flush      = 3'd0,  // Sweeping valid bits clear after reset
		st_idle       = 3'd1,  // Idle or serving hits
		st_fill_inst  = 3'd2,  // Instruction miss
		st_fill_both  = 3'd3,  // Instruction miss, data miss follows
		st_fill_data  = 3'd4,  // Data miss
		st_write      = 3'd5,  // Data write-through
		st_write_inst = 3'd6   // Instruction miss, data write follows
	} cache_state_t;

endpackage

// File: rtl/memory_hierarchy.sv
`timescale 1ns/100ps

module memory_hierarchy #(
	parameter int INDEX_W     = 6,       // Cache index bits
	parameter int MEM_WORDS   = 1024,
	parameter int MEM_LATENCY = 4
) (
	input  logic                       clk,
	input  logic                       reset,
	input  logic                       ie,
	input  logic                       de,
	input  logic                       drw,
	input  logic [mem_pkg::ADDR_W-1:0] iaddr,
	input  logic [mem_pkg::ADDR_W-1:0] daddr,
	input  logic [mem_pkg::WORD_W-1:0] din,
	output logic [mem_pkg::WORD_W-1:0] iout,
	output logic [mem_pkg::WORD_W-1:0] dout,
	output logic                       cpu_stall
);

	localparam int TAGV_W = mem_pkg::ADDR_W - INDEX_W + 1;  // Tag plus valid

	logic                       inst_wr, data_wr;
	logic [INDEX_W-1:0]         inst_index, data_index;
	logic [mem_pkg::WORD_W-1:0] inst_word_d, data_word_d, inst_word_q, data_word_q;
	logic [TAGV_W-1:0]          inst_tag_d, data_tag_d, inst_tag_q, data_tag_q;
	logic                       mem_req, mem_we, mem_rdy;
	logic [mem_pkg::ADDR_W-1:0] mem_addr;
	logic [mem_pkg::WORD_W-1:0] mem_wdata, mem_rdata;

	cache_controller #(.INDEX_W(INDEX_W)) cache_controller_inst (
		.clk, .reset, .ie, .de, .drw, .iaddr, .daddr, .din,
		.inst_tag_q, .data_tag_q, .inst_word_q, .data_word_q,
		.inst_wr, .data_wr, .inst_index, .data_index,
		.inst_word_d, .data_word_d, .inst_tag_d, .data_tag_d,
		.mem_req, .mem_we, .mem_addr, .mem_wdata, .mem_rdy, .mem_rdata,
		.iout, .dout, .cpu_stall
	);

	// Port a carries the cache traffic, port b is a spare read port
	cache_array #(.ADDR_BITS(INDEX_W), .DATA_BITS(mem_pkg::WORD_W)) inst_data_inst (
		.clk, .wea(inst_wr), .web(1'b0), .addra(inst_index), .addrb(inst_index),
		.dia(inst_word_d), .dib('0), .doa(inst_word_q), .dob()
	);

	cache_array #(.ADDR_BITS(INDEX_W), .DATA_BITS(TAGV_W)) inst_tag_inst (
		.clk, .wea(inst_wr), .web(1'b0), .addra(inst_index), .addrb(inst_index),
		.dia(inst_tag_d), .dib('0), .doa(inst_tag_q), .dob()
	);

	cache_array #(.ADDR_BITS(INDEX_W), .DATA_BITS(mem_pkg::WORD_W)) data_data_inst (
		.clk, .wea(data_wr), .web(1'b0), .addra(data_index), .addrb(data_index),
		.dia(data_word_d), .dib('0), .doa(data_word_q), .dob()
	);

	cache_array #(.ADDR_BITS(INDEX_W), .DATA_BITS(TAGV_W)) data_tag_inst (
		.clk, .wea(data_wr), .web(1'b0), .addra(data_index), .addrb(data_index),
		.dia(data_tag_d), .dib('0), .doa(data_tag_q), .dob()
	);

	backing_memory #(
		.MEM_WORDS(MEM_WORDS),
		.MEM_LATENCY(MEM_LATENCY)
	) backing_memory_inst (
		.clk, .reset, .mem_req, .mem_we, .mem_addr, .mem_wdata,
		.mem_rdy, .mem_rdata
	);

endmodule

// File: run.sh
#!/bin/sh
# Builds and runs the memory hierarchy testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module memory_hierarchy_tb \
	-f sources.f \
	-Mdir obj_dir \
	-o sim

# The log decides the result, so a non-zero exit of the model is tolerated here
./obj_dir/sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
if ! grep -q "TEST PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

// File: sources.f
rtl/mem_pkg.sv
rtl/cache_array.sv
rtl/cache_controller.sv
rtl/backing_memory.sv
rtl/memory_hierarchy.sv
bench/memory_hierarchy_tb.sv
